/* logic/bram_ctrl_config.svh */
`ifndef BRAM_CTRL_CONFIG_SVH
`define BRAM_CTRL_CONFIG_SVH

//////////////////////////////////////////////////
// Row buffer geometry
//////////////////////////////////////////////////

// Words per row buffer
`define BRAM_DEPTH 1024

// Row and column index, one bit under log2 of depth
`define IDX_W ($clog2(`BRAM_DEPTH) - 1)

// Sequencer memory holds five words per buffer pair
`define SEQ_W ($clog2((`BRAM_DEPTH / 2) * 5))

// Prefetch fill count width
`define PFB_COUNT_W 18

//////////////////////////////////////////////////
// Pipeline timing
//////////////////////////////////////////////////

// Read latency of the buffers
`define DELAY_CYCLES 2

// Last value of the five-step cycle counter
`define CYCLE_WRAP 4

`endif

/* logic/bram_ctrl_pkg.sv */
`include "bram_ctrl_config.svh"

package bram_ctrl_pkg;

    //////////////////////////////////////////////////
    // Phase machine
    //////////////////////////////////////////////////

    // One-hot phase encoding
    typedef enum logic [6:0] {
        ST_IDLE           = 7'b0000001,
        ST_LOAD_SEQUENCER = 7'b0000010,
        ST_PRIM_BUFFER_0  = 7'b0000100,
        ST_PRIM_BUFFER_1  = 7'b0001000,
        ST_LOAD_PFB       = 7'b0010000,
        ST_ACTIVE         = 7'b0100000,
        ST_FIN_ROW_MATRIC = 7'b1000000
    } state_t;

    //////////////////////////////////////////////////
    // Indices and counts
    //////////////////////////////////////////////////

    // Row or column of a map
    typedef logic [`IDX_W-1:0] idx_t;

    // Sequencer memory address
    typedef logic [`SEQ_W-1:0] seq_addr_t;

    // Sequencer fill count, one bit wider than the address
    typedef logic [`SEQ_W:0] seq_cnt_t;

    // Prefetch buffer fill count
    typedef logic [`PFB_COUNT_W-1:0] pfb_cnt_t;

    // Five-step cycle counter
    typedef logic [2:0] cycle_t;

endpackage

/* logic/scan_if.sv */
`timescale 1ns/1ps

interface scan_if;

    // Pixel taken this cycle
    logic pix_accept;

    // Last column of input row 2 reached
    logic prime_done;

    // Same test two cycles later
    logic prime_drained;

    // Last output column with row_matric high
    logic out_row_end;

    // Row end on the last output row
    logic out_map_end;

    // Phase machine side
    modport fsm (
        output pix_accept,
        input  prime_done,
        input  prime_drained,
        input  out_row_end,
        input  out_map_end
    );

    // Counter side
    modport scan (
        input  pix_accept,
        output prime_done,
        output prime_drained,
        output out_row_end,
        output out_map_end
    );

endinterface

/* logic/delay_line.sv */
`timescale 1ns/1ps
`include "bram_ctrl_config.svh"

module delay_line
    import bram_ctrl_pkg::*;
#(
    parameter type T     = idx_t,
    parameter int  DEPTH = `DELAY_CYCLES
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    // Stage 0 takes the input, last stage drives the output
    T stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

/* logic/pixel_scan.sv */
`timescale 1ns/1ps
`include "bram_ctrl_config.svh"

module pixel_scan
    import bram_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic row_matric,
    input  idx_t num_input_cols,
    input  idx_t num_output_rows,
    input  idx_t num_output_cols,
    scan_if.scan sc,
    output idx_t input_col,
    output idx_t input_col_d,
    output idx_t input_row_d
);

    idx_t input_row;
    idx_t output_col;
    idx_t output_row;
    logic in_col_last;

    assign in_col_last = (input_col == num_input_cols);

    //////////////////////////////////////////////////
    // Input scan
    //////////////////////////////////////////////////

    // One step per accepted pixel
    // Whole scan restarts when the map is finished
    always_ff @(posedge clk) begin
        if (rst || sc.out_map_end) begin
            input_col <= '0;
            input_row <= '0;
        end else if (sc.pix_accept) begin
            if (in_col_last) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    // Copies aligned with buffer read data
    delay_line #(
        .T     (idx_t),
        .DEPTH (`DELAY_CYCLES)
    ) u_col_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (input_col),
        .dout (input_col_d)
    );

    delay_line #(
        .T     (idx_t),
        .DEPTH (`DELAY_CYCLES)
    ) u_row_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (input_row),
        .dout (input_row_d)
    );

    //////////////////////////////////////////////////
    // Output scan
    //////////////////////////////////////////////////

    // One column per row_matric pulse
    always_ff @(posedge clk) begin
        if (rst || sc.out_map_end) begin
            output_col <= '0;
            output_row <= '0;
        end else if (sc.out_row_end) begin
            output_col <= '0;
            output_row <= output_row + 1'b1;
        end else if (row_matric) begin
            output_col <= output_col + 1'b1;
        end
    end

    // Status flags
    // Priming ends on row 2, the third input row
    assign sc.prime_done    = (input_row == idx_t'(2)) && in_col_last;
    assign sc.prime_drained = (input_row_d == idx_t'(2)) && (input_col_d == num_input_cols);
    assign sc.out_row_end   = (output_col == num_output_cols) && row_matric;
    assign sc.out_map_end   = sc.out_row_end && (output_row == num_output_rows);

endmodule

/* logic/seq_addr_ctrl.sv */
`timescale 1ns/1ps
`include "bram_ctrl_config.svh"

module seq_addr_ctrl
    import bram_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      seq_wren,
    input  logic      active,
    input  seq_cnt_t  seq_count,
    output seq_addr_t seq_wr_addr,
    output seq_addr_t seq_rd_addr,
    output logic      seq_rden,
    output cycle_t    cycle_counter
);

    logic rd_go;
    logic rden_d;

    // Reads run once the sequencer holds more than two words
    assign rd_go = active && (seq_count > seq_cnt_t'(2));

    //////////////////////////////////////////////////
    // Sequencer addresses
    //////////////////////////////////////////////////

    // Write address follows each write strobe
    // Empty sequencer means the next map starts at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_wr_addr <= '0;
        end else if (seq_wren) begin
            seq_wr_addr <= seq_wr_addr + 1'b1;
        end else if (seq_count == '0) begin
            seq_wr_addr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rden    <= 1'b0;
            seq_rd_addr <= '0;
        end else if (rd_go) begin
            seq_rden    <= 1'b1;
            seq_rd_addr <= seq_rd_addr + 1'b1;
        end else begin
            seq_rden    <= 1'b0;
            seq_rd_addr <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Cycle counter
    //////////////////////////////////////////////////

    // Read strobe lined up with sequencer data
    delay_line #(
        .T     (logic),
        .DEPTH (`DELAY_CYCLES)
    ) u_rden_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (seq_rden),
        .dout (rden_d)
    );

    // Five steps per sequencer word group
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
        end else if (active && rden_d) begin
            if (cycle_counter == cycle_t'(`CYCLE_WRAP)) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

endmodule

/* logic/bram_phase_fsm.sv */
`timescale 1ns/1ps

module bram_phase_fsm
    import bram_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       datain_valid,
    input  logic       pixel_datain_tag,
    input  logic       seq_datain_tag,
    input  logic       new_map,
    input  logic       row_matric,
    input  seq_cnt_t   seq_count,
    input  pfb_cnt_t   pfb_count,
    input  seq_cnt_t   seq_full_count,
    input  idx_t       num_input_cols,
    input  idx_t       row_matric_done_count,
    scan_if.fsm        sc,
    output state_t     state,
    output logic       pixel_datain_rdy,
    output logic       seq_datain_rdy,
    output logic       seq_wren,
    output logic       seq_count_rst,
    output logic       seq_count_set,
    output logic       pfb_wren,
    output logic       pfb_rden,
    output logic       pixel_valid_early,
    output logic       row_matric_done,
    output logic [1:0] gray_code
);

    idx_t       row_matric_count;
    logic [1:0] gc;
    logic       pix_in;
    logic       seq_in;
    logic       last_seq;
    logic       last_pix;
    logic       last_pfb;
    logic       fin_last;

    //////////////////////////////////////////////////
    // Phase end conditions
    //////////////////////////////////////////////////

    assign pix_in = datain_valid && pixel_datain_tag;
    assign seq_in = datain_valid && seq_datain_tag;

    // Final write in flight, external count still one behind
    assign last_seq = seq_wren && (seq_count + 1'b1 == seq_full_count);
    assign last_pfb = pfb_wren && (pfb_count == pfb_cnt_t'(num_input_cols));

    // Last pixel of input row 2 taken this cycle
    assign last_pix = sc.pix_accept && sc.prime_done;

    assign fin_last = (row_matric_count == row_matric_done_count);

    // Every pixel ready cycle is an accepted pixel
    assign sc.pix_accept = pixel_datain_rdy;

    assign row_matric_done = (state == ST_FIN_ROW_MATRIC) && fin_last;

    // Binary count mapped to 00 01 11 10
    assign gray_code = {gc[1], gc[1] ^ gc[0]};

    //////////////////////////////////////////////////
    // Phase machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            pixel_datain_rdy  <= 1'b0;
            seq_datain_rdy    <= 1'b0;
            seq_wren          <= 1'b0;
            seq_count_rst     <= 1'b0;
            seq_count_set     <= 1'b0;
            pfb_wren          <= 1'b0;
            pfb_rden          <= 1'b0;
            pixel_valid_early <= 1'b0;
            row_matric_count  <= '0;
            gc                <= '0;
        end else begin
            // Strobes last one cycle unless renewed
            pixel_datain_rdy  <= 1'b0;
            seq_datain_rdy    <= 1'b0;
            seq_wren          <= 1'b0;
            seq_count_rst     <= 1'b0;
            seq_count_set     <= 1'b0;
            pfb_wren          <= 1'b0;
            pfb_rden          <= 1'b0;
            pixel_valid_early <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (new_map) begin
                        state <= ST_LOAD_SEQUENCER;
                    end
                end
                ST_LOAD_SEQUENCER: begin
                    // Stream sequencer words into memory
                    seq_wren       <= seq_in && !last_seq;
                    seq_datain_rdy <= seq_in && !last_seq;
                    if (last_seq) begin
                        state <= ST_PRIM_BUFFER_0;
                    end
                end
                ST_PRIM_BUFFER_0: begin
                    // First three rows go to the pixel buffer
                    if (pix_in && !last_pix) begin
                        pixel_datain_rdy <= 1'b1;
                        pfb_wren         <= 1'b1;
                        pfb_rden         <= 1'b1;
                    end
                    if (last_pix) begin
                        state <= ST_PRIM_BUFFER_1;
                    end
                end
                ST_PRIM_BUFFER_1: begin
                    // Wait out the buffer read latency
                    if (sc.prime_drained) begin
                        state <= ST_LOAD_PFB;
                    end
                end
                ST_LOAD_PFB: begin
                    // One input row into the prefetch buffer
                    if (pix_in && !last_pfb) begin
                        pixel_datain_rdy <= 1'b1;
                        pfb_wren         <= 1'b1;
                    end
                    if (last_pfb) begin
                        state <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    pfb_rden          <= row_matric;
                    pixel_valid_early <= !sc.out_row_end;
                    if (sc.out_map_end) begin
                        // Map done, sequencer emptied
                        seq_count_rst <= 1'b1;
                        state         <= ST_IDLE;
                    end else if (sc.out_row_end) begin
                        // Sequencer rewound for the next row
                        seq_count_set <= 1'b1;
                        state         <= ST_FIN_ROW_MATRIC;
                    end
                end
                ST_FIN_ROW_MATRIC: begin
                    // Flush the row matrix out of the prefetch buffer
                    pfb_rden         <= !fin_last;
                    row_matric_count <= row_matric_count + 1'b1;
                    if (fin_last) begin
                        row_matric_count <= '0;
                        gc               <= gc + 1'b1;
                        state            <= ST_LOAD_PFB;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/octo_bram_ctrl.sv */
`timescale 1ns/1ps
`include "bram_ctrl_config.svh"

module octo_bram_ctrl
    import bram_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       datain_valid,
    input  logic       pixel_datain_tag,
    input  logic       seq_datain_tag,
    input  logic       new_map,
    input  logic       row_matric,
    input  seq_cnt_t   seq_count,
    input  pfb_cnt_t   pfb_count,
    input  idx_t       num_input_cols,
    input  idx_t       num_output_rows,
    input  idx_t       num_output_cols,
    input  seq_cnt_t   seq_full_count,
    input  idx_t       row_matric_done_count,
    output logic       pixel_datain_rdy,
    output logic       pixel_dataout_valid,
    output seq_addr_t  seq_wr_addr,
    output seq_addr_t  seq_rd_addr,
    output logic       seq_wren,
    output logic       seq_rden,
    output logic       seq_datain_rdy,
    output logic       seq_count_rst,
    output logic       seq_count_set,
    output state_t     state,
    output idx_t       input_row_d,
    output idx_t       input_col,
    output idx_t       input_col_d,
    output logic [1:0] gray_code,
    output cycle_t     cycle_counter,
    output logic       pfb_wren,
    output logic       pfb_rden,
    output logic       pfb_rden_d,
    output logic       row_matric_done
);

    logic active;
    logic pixel_valid_early;

    // Sequencer reads only in the active phase
    assign active = (state == ST_ACTIVE);

    // Status between phase machine and counters
    scan_if sc ();

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    bram_phase_fsm u_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .datain_valid          (datain_valid),
        .pixel_datain_tag      (pixel_datain_tag),
        .seq_datain_tag        (seq_datain_tag),
        .new_map               (new_map),
        .row_matric            (row_matric),
        .seq_count             (seq_count),
        .pfb_count             (pfb_count),
        .seq_full_count        (seq_full_count),
        .num_input_cols        (num_input_cols),
        .row_matric_done_count (row_matric_done_count),
        .sc                    (sc.fsm),
        .state                 (state),
        .pixel_datain_rdy      (pixel_datain_rdy),
        .seq_datain_rdy        (seq_datain_rdy),
        .seq_wren              (seq_wren),
        .seq_count_rst         (seq_count_rst),
        .seq_count_set         (seq_count_set),
        .pfb_wren              (pfb_wren),
        .pfb_rden              (pfb_rden),
        .pixel_valid_early     (pixel_valid_early),
        .row_matric_done       (row_matric_done),
        .gray_code             (gray_code)
    );

    pixel_scan u_scan (
        .clk             (clk),
        .rst             (rst),
        .row_matric      (row_matric),
        .num_input_cols  (num_input_cols),
        .num_output_rows (num_output_rows),
        .num_output_cols (num_output_cols),
        .sc              (sc.scan),
        .input_col       (input_col),
        .input_col_d     (input_col_d),
        .input_row_d     (input_row_d)
    );

    seq_addr_ctrl u_seq (
        .clk           (clk),
        .rst           (rst),
        .seq_wren      (seq_wren),
        .active        (active),
        .seq_count     (seq_count),
        .seq_wr_addr   (seq_wr_addr),
        .seq_rd_addr   (seq_rd_addr),
        .seq_rden      (seq_rden),
        .cycle_counter (cycle_counter)
    );

    //////////////////////////////////////////////////
    // Read latency alignment
    //////////////////////////////////////////////////

    delay_line #(
        .T     (logic),
        .DEPTH (`DELAY_CYCLES)
    ) u_pfb_rden_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (pfb_rden),
        .dout (pfb_rden_d)
    );

    // Output valid tracks the buffer data
    delay_line #(
        .T     (logic),
        .DEPTH (`DELAY_CYCLES)
    ) u_valid_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (pixel_valid_early),
        .dout (pixel_dataout_valid)
    );

endmodule

/* test/octo_bram_asserts.sv */
`timescale 1ns/1ps

module octo_bram_asserts
    import bram_ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input state_t     state,
    input logic       pfb_wren,
    input logic       pixel_datain_rdy,
    input logic       seq_wren,
    input logic       seq_datain_rdy,
    input logic       seq_count_set,
    input logic [1:0] gray_code
);

    // Phase register never holds two phases
    assert property (@(posedge clk) disable iff (rst) $onehot(state))
        else $error("state is not one-hot");

    // Buffer writes only with an accepted pixel
    assert property (@(posedge clk) disable iff (rst) pfb_wren |-> pixel_datain_rdy)
        else $error("pfb_wren without pixel_datain_rdy");

    // Gray sequence, one bit per step
    assert property (@(posedge clk) disable iff (rst)
        $countones(gray_code ^ $past(gray_code)) <= 1)
        else $error("gray_code changed by more than one bit");

    // Sequencer quiet while idle
    assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !(seq_wren || seq_datain_rdy || seq_count_set))
        else $error("sequencer strobe high in idle");

endmodule

bind bram_phase_fsm octo_bram_asserts u_asserts (.*);

/* test/tb_octo_bram_ctrl.sv */
`timescale 1ns/1ps

module tb_octo_bram_ctrl
    import bram_ctrl_pkg::*;
();

    typedef struct {
        int in_cols;
        int out_rows;
        int out_cols;
        int full;
        int done_cnt;
        int exp_wren;
        int exp_prim;
        int exp_pfb;
        int exp_sets;
    } map_cfg_t;

    // Config columns followed by expected wren, priming rdy, pfb load and row finish counts
    map_cfg_t maps [3] = '{
        '{4, 2, 3, 7, 2, 7, 15, 5, 2},
        '{2, 1, 1, 5, 1, 5, 9, 3, 1},
        '{6, 3, 2, 10, 0, 10, 21, 7, 3}
    };
    logic [1:0] gray_seq [4] = '{2'b00, 2'b01, 2'b11, 2'b10};

    logic clk = 1'b0;
    logic rst, new_map, row_matric;
    logic datain_valid = 1'b0;
    logic pixel_datain_tag = 1'b0;
    logic seq_datain_tag = 1'b0;
    seq_cnt_t seq_count = '0;
    pfb_cnt_t pfb_count = '0;
    idx_t num_input_cols, num_output_rows, num_output_cols, row_matric_done_count;
    seq_cnt_t seq_full_count;
    logic pixel_datain_rdy, pixel_dataout_valid, seq_wren, seq_rden, seq_datain_rdy;
    logic seq_count_rst, seq_count_set, pfb_wren, pfb_rden, pfb_rden_d, row_matric_done;
    seq_addr_t seq_wr_addr, seq_rd_addr;
    state_t state;
    idx_t input_row_d, input_col, input_col_d;
    logic [1:0] gray_code;
    cycle_t cycle_counter;

    int errors = 0;
    int n_tests = 0;
    int n_failed = 0;
    int prim_rdy_cnt = 0;
    int wren_cnt = 0;
    int seq_rdy_cnt = 0;
    int set_cnt = 0;
    int rst_cnt = 0;
    int row_done_cnt = 0;
    logic [1:0] rden_hist = '0;
    logic [1:0] valid_hist = '0;
    idx_t col_hist0 = '0;
    idx_t col_hist1 = '0;

    octo_bram_ctrl dut0 (.*);

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_state(input state_t got, input state_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %s expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_idx(input idx_t got, input idx_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bits(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Wait for a phase, sampling state at the clock edge
    task automatic wait_state(input state_t s, input int limit);
        int n;
        n = 0;
        while (state != s && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (state != s) begin
            $display("Timed out after %0d cycles waiting for state %s", limit, s.name());
            $display("SOME TESTS FAILED");
            $finish;
        end
    endtask

    //////////////////////////////////////////////////
    // External models and monitors
    //////////////////////////////////////////////////

    // Sequencer fill count and prefetch fill count
    always @(posedge clk) begin
        if (rst || seq_count_rst) begin
            seq_count <= '0;
        end else if (seq_wren) begin
            seq_count <= seq_count + 1'b1;
        end
        if (rst || state != ST_LOAD_PFB) begin
            pfb_count <= '0;
        end else if (pfb_wren) begin
            pfb_count <= pfb_count + 1'b1;
        end
    end

    // Random gaps in datain_valid with the tag chosen by phase
    always @(posedge clk) begin
        if (rst) begin
            datain_valid     <= 1'b0;
            seq_datain_tag   <= 1'b0;
            pixel_datain_tag <= 1'b0;
        end else begin
            datain_valid     <= ($urandom % 4) != 0;
            seq_datain_tag   <= (state == ST_IDLE) || (state == ST_LOAD_SEQUENCER);
            pixel_datain_tag <= !((state == ST_IDLE) || (state == ST_LOAD_SEQUENCER));
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            // Two-cycle read latency copies
            check_bits(32'(pfb_rden_d), 32'(rden_hist[1]), "pfb_rden_d");
            check_bits(32'(pixel_dataout_valid), 32'(valid_hist[1]), "pixel_dataout_valid");
            check_idx(input_col_d, col_hist1, "input_col_d");
            if (cycle_counter > 3'd4) begin
                check_count(int'(cycle_counter), 4, "cycle_counter range");
            end
            rden_hist    <= {rden_hist[0], pfb_rden};
            valid_hist   <= {valid_hist[0], dut0.pixel_valid_early};
            col_hist0    <= input_col;
            col_hist1    <= col_hist0;
            prim_rdy_cnt <= prim_rdy_cnt + int'(pixel_datain_rdy && state == ST_PRIM_BUFFER_0);
            wren_cnt     <= wren_cnt + int'(seq_wren);
            seq_rdy_cnt  <= seq_rdy_cnt + int'(seq_datain_rdy);
            set_cnt      <= set_cnt + int'(seq_count_set);
            rst_cnt      <= rst_cnt + int'(seq_count_rst);
            row_done_cnt <= row_done_cnt + int'(row_matric_done);
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int base_wren, base_rdy, base_prim, base_set, base_rst, base_done;
        int err0, fin_total, gap;
        state_t after_row;
        void'($urandom(32'h397fef09));
        fin_total = 0;
        rst = 1'b1;
        new_map = 1'b0;
        row_matric = 1'b0;
        num_input_cols = '0;
        num_output_rows = '0;
        num_output_cols = '0;
        row_matric_done_count = '0;
        seq_full_count = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset values
        err0 = errors;
        check_state(state, ST_IDLE, "state after reset");
        check_bits(32'({seq_wren, seq_rden, seq_datain_rdy, seq_count_rst, seq_count_set}), 0,
                   "sequencer strobes after reset");
        check_bits(32'({pfb_wren, pfb_rden, pfb_rden_d, pixel_datain_rdy, pixel_dataout_valid,
                        row_matric_done}), 0,
                   "buffer strobes after reset");
        check_bits(32'(gray_code), 0, "gray_code after reset");
        check_bits(32'(cycle_counter), 0, "cycle_counter after reset");
        check_bits(32'(seq_wr_addr), 0, "seq_wr_addr after reset");
        check_bits(32'(seq_rd_addr), 0, "seq_rd_addr after reset");
        check_idx(input_row_d, '0, "input_row_d after reset");
        n_tests++;
        n_failed += int'(errors != err0);
        $display("test reset: %s", (errors == err0) ? "pass" : "FAIL");

        foreach (maps[m]) begin
            err0 = errors;
            base_wren = wren_cnt;
            base_rdy = seq_rdy_cnt;
            base_prim = prim_rdy_cnt;
            base_set = set_cnt;
            base_rst = rst_cnt;
            base_done = row_done_cnt;
            num_input_cols        <= idx_t'(maps[m].in_cols);
            num_output_rows       <= idx_t'(maps[m].out_rows);
            num_output_cols       <= idx_t'(maps[m].out_cols);
            seq_full_count        <= seq_cnt_t'(maps[m].full);
            row_matric_done_count <= idx_t'(maps[m].done_cnt);
            @(posedge clk);
            new_map <= 1'b1;
            @(posedge clk);
            new_map <= 1'b0;

            wait_state(ST_PRIM_BUFFER_0, 200);
            check_count(wren_cnt - base_wren, maps[m].exp_wren, "seq_wren pulses");
            check_count(seq_rdy_cnt - base_rdy, maps[m].exp_wren, "seq_datain_rdy pulses");
            check_bits(32'(seq_wr_addr), 32'(maps[m].full), "seq_wr_addr after load");
            wait_state(ST_LOAD_PFB, 400);
            check_count(prim_rdy_cnt - base_prim, maps[m].exp_prim, "priming rdy cycles");

            for (int r = 0; r <= maps[m].out_rows; r++) begin
                wait_state(ST_ACTIVE, 200);
                check_count(int'(pfb_count), maps[m].exp_pfb, "pfb_wren pulses per row");
                for (int j = 0; j <= maps[m].out_cols; j++) begin
                    gap = $urandom % 3;
                    repeat (gap) @(posedge clk);
                    row_matric <= 1'b1;
                    @(posedge clk);
                    row_matric <= 1'b0;
                    @(posedge clk);
                    if (j < maps[m].out_cols) begin
                        after_row = ST_ACTIVE;
                    end else if (r < maps[m].out_rows) begin
                        after_row = ST_FIN_ROW_MATRIC;
                    end else begin
                        after_row = ST_IDLE;
                    end
                    check_state(state, after_row, "state after row_matric");
                end
                if (r < maps[m].out_rows) begin
                    wait_state(ST_LOAD_PFB, 100);
                    fin_total++;
                    check_bits(32'(gray_code), 32'(gray_seq[fin_total % 4]), "gray_code");
                end
            end

            // Let the final reset pulse reach the counters
            repeat (3) @(posedge clk);
            check_count(set_cnt - base_set, maps[m].exp_sets, "seq_count_set pulses");
            check_count(row_done_cnt - base_done, maps[m].exp_sets, "row_matric_done pulses");
            check_count(rst_cnt - base_rst, 1, "seq_count_rst pulses");
            check_idx(input_col, '0, "input_col after map");
            check_idx(input_row_d, '0, "input_row_d after map");
            check_bits(32'(seq_rd_addr), 0, "seq_rd_addr after map");
            n_tests++;
            n_failed += int'(errors != err0);
            $display("test map %0d: %s", m, (errors == err0) ? "pass" : "FAIL");
        end

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+logic
logic/bram_ctrl_pkg.sv
logic/scan_if.sv
logic/delay_line.sv
logic/pixel_scan.sv
logic/seq_addr_ctrl.sv
logic/bram_phase_fsm.sv
logic/octo_bram_ctrl.sv
test/octo_bram_asserts.sv
test/tb_octo_bram_ctrl.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_octo_bram_ctrl -Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_octo_bram_ctrl > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1
